// ==== exu_ecl.f ====
src/exu_ecl_pkg.sv
src/exu_operand_bypass.sv
src/exu_e2m_pipe.sv
src/exu_trap_ctrl.sv
src/exu_wb_select.sv
src/exu_ecl.sv
verif/exu_ecl_props.sv
verif/exu_ecl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the exu_ecl testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=exu_ecl_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module exu_ecl_tb -f exu_ecl.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $LOG"
   exit 1
fi

// ==== src/exu_e2m_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_e2m_pipe #(
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  kill_e,

   input  logic                  alu_wen_e,
   input  logic                  mul_valid_e,
   input  logic                  mul_wen_e,
   input  logic                  lsu_valid_e,
   input  logic                  lsu_wen_e,
   input  exu_ecl_pkg::reg_idx_t rf_target_e,
   input  exu_ecl_pkg::reg_idx_t lsu_rd_e,
   input  logic [DATA_W-1:0]     alu_res_e,

   input  logic                  lsu_data_valid,
   input  logic                  lsu_wr_fin,
   input  logic                  lsu_ale_e,

   output logic                  lsu_valid,
   output logic                  mul_valid,
   output logic                  alu_wen_m,
   output logic                  mul_valid_m,
   output logic                  mul_wen_m,
   output exu_ecl_pkg::reg_idx_t rf_target_m,
   output logic [DATA_W-1:0]     alu_res_m,
   output exu_ecl_pkg::reg_idx_t lsu_rd_m,
   output logic                  lsu_wen_m,
   output logic                  stall_req
);

   logic lsu_pend;
   logic lsu_fin;

   // an interrupt taken in E cancels the unit strobes
   assign lsu_valid = lsu_valid_e & ~kill_e;
   assign mul_valid = mul_valid_e & ~kill_e;

   //////////////////////////////////////////////////
   // alu / mul write info, E to M
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_wen_m   <= 1'b0;
         mul_valid_m <= 1'b0;
         mul_wen_m   <= 1'b0;
      end else begin
         alu_wen_m   <= alu_wen_e & ~kill_e;
         mul_valid_m <= mul_valid;
         mul_wen_m   <= mul_wen_e & ~kill_e;
      end
   end

   always_ff @(posedge clk) begin
      rf_target_m <= rf_target_e;
      alu_res_m   <= alu_res_e;
   end

   //////////////////////////////////////////////////
   // load destination and stall tracking
   //////////////////////////////////////////////////

   // held until the next load or store issues
   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_wen_m <= 1'b0;
      end else if (lsu_valid) begin
         lsu_wen_m <= lsu_wen_e;
      end
   end

   always_ff @(posedge clk) begin
      if (lsu_valid) begin
         lsu_rd_m <= lsu_rd_e;
      end
   end

   // an ale aborts the bus request, so it also ends the access
   assign lsu_fin = lsu_data_valid | lsu_wr_fin | lsu_ale_e;

   // a misaligned issue never becomes pending
   always_ff @(posedge clk) begin
      if (reset) begin
         lsu_pend <= 1'b0;
      end else begin
         lsu_pend <= (lsu_valid & ~lsu_ale_e) | (lsu_pend & ~lsu_fin);
      end
   end

   // high already in the issue cycle
   assign stall_req = lsu_pend | lsu_valid;

endmodule

`default_nettype wire

// ==== src/exu_ecl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_ecl #(
   parameter int DATA_W = exu_ecl_pkg::GRLEN
) (
   input  logic                  clk,
   input  logic                  reset,

   // operands
   input  exu_ecl_pkg::reg_idx_t rs1_e,
   input  exu_ecl_pkg::reg_idx_t rs2_e,
   input  logic [DATA_W-1:0]     rf_a_e,
   input  logic [DATA_W-1:0]     rf_b_e,
   input  logic                  b_imm_e,

   // alu and mul
   input  exu_ecl_pkg::reg_idx_t rf_target_e,
   input  logic                  alu_wen_e,
   input  logic [DATA_W-1:0]     alu_res_e,
   input  logic                  mul_valid_e,
   input  logic                  mul_wen_e,
   input  logic [DATA_W-1:0]     mul_res_m,

   // lsu
   input  logic                  lsu_valid_e,
   input  logic                  lsu_wen_e,
   input  exu_ecl_pkg::reg_idx_t lsu_rd_e,
   input  logic [DATA_W-1:0]     lsu_rdata_m,
   input  logic                  lsu_data_valid,
   input  logic                  lsu_wr_fin,
   input  logic                  lsu_ale_e,

   // traps
   input  logic                  valid_e,
   input  logic                  exception_e,
   input  exu_ecl_pkg::exccode_t exccode_e,
   input  logic                  crmd_ie,
   input  logic                  timer_intr,
   input  logic                  ext_intr,

   output logic [DATA_W-1:0]     opnd_a_e,
   output logic [DATA_W-1:0]     opnd_b_e,
   output logic                  lsu_valid,
   output logic                  mul_valid,
   output logic                  except,
   output exu_ecl_pkg::exccode_t exccode,
   output logic                  stall_req,
   output exu_ecl_pkg::reg_idx_t irf_rd_w,
   output logic                  irf_wen_w,
   output logic [DATA_W-1:0]     irf_rd_data_w
);

   logic                  kill_e;
   logic                  alu_wen_m;
   logic                  mul_valid_m;
   logic                  mul_wen_m;
   exu_ecl_pkg::reg_idx_t rf_target_m;
   logic [DATA_W-1:0]     alu_res_m;
   exu_ecl_pkg::reg_idx_t lsu_rd_m;
   logic                  lsu_wen_m;
   exu_ecl_pkg::reg_idx_t rd_m;
   logic                  wen_m;
   logic [DATA_W-1:0]     rd_data_m;

   // lsu base and store data are opnd_a_e / opnd_b_e
   exu_operand_bypass #(.DATA_W(DATA_W)) i_bypass (
      .rs1_e     (rs1_e),
      .rs2_e     (rs2_e),
      .rf_a_e    (rf_a_e),
      .rf_b_e    (rf_b_e),
      .b_imm_e   (b_imm_e),
      .rd_m      (rd_m),
      .rd_w      (irf_rd_w),
      .wen_m     (wen_m),
      .wen_w     (irf_wen_w),
      .rd_data_m (rd_data_m),
      .rd_data_w (irf_rd_data_w),
      .opnd_a_e  (opnd_a_e),
      .opnd_b_e  (opnd_b_e)
   );

   exu_e2m_pipe #(.DATA_W(DATA_W)) i_e2m_pipe (
      .clk            (clk),
      .reset          (reset),
      .kill_e         (kill_e),
      .alu_wen_e      (alu_wen_e),
      .mul_valid_e    (mul_valid_e),
      .mul_wen_e      (mul_wen_e),
      .lsu_valid_e    (lsu_valid_e),
      .lsu_wen_e      (lsu_wen_e),
      .rf_target_e    (rf_target_e),
      .lsu_rd_e       (lsu_rd_e),
      .alu_res_e      (alu_res_e),
      .lsu_data_valid (lsu_data_valid),
      .lsu_wr_fin     (lsu_wr_fin),
      .lsu_ale_e      (lsu_ale_e),
      .lsu_valid      (lsu_valid),
      .mul_valid      (mul_valid),
      .alu_wen_m      (alu_wen_m),
      .mul_valid_m    (mul_valid_m),
      .mul_wen_m      (mul_wen_m),
      .rf_target_m    (rf_target_m),
      .alu_res_m      (alu_res_m),
      .lsu_rd_m       (lsu_rd_m),
      .lsu_wen_m      (lsu_wen_m),
      .stall_req      (stall_req)
   );

   exu_trap_ctrl i_trap_ctrl (
      .clk         (clk),
      .reset       (reset),
      .valid_e     (valid_e),
      .exception_e (exception_e),
      .lsu_ale_e   (lsu_ale_e),
      .exccode_e   (exccode_e),
      .crmd_ie     (crmd_ie),
      .timer_intr  (timer_intr),
      .ext_intr    (ext_intr),
      .except      (except),
      .exccode     (exccode),
      .kill_e      (kill_e)
   );

   exu_wb_select #(.DATA_W(DATA_W)) i_wb_select (
      .clk            (clk),
      .reset          (reset),
      .alu_wen_m      (alu_wen_m),
      .mul_valid_m    (mul_valid_m),
      .mul_wen_m      (mul_wen_m),
      .rf_target_m    (rf_target_m),
      .alu_res_m      (alu_res_m),
      .lsu_rd_m       (lsu_rd_m),
      .lsu_wen_m      (lsu_wen_m),
      .lsu_data_valid (lsu_data_valid),
      .lsu_rdata_m    (lsu_rdata_m),
      .mul_res_m      (mul_res_m),
      .rd_m           (rd_m),
      .wen_m          (wen_m),
      .rd_data_m      (rd_data_m),
      .irf_rd_w       (irf_rd_w),
      .irf_wen_w      (irf_wen_w),
      .irf_rd_data_w  (irf_rd_data_w)
   );

endmodule

`default_nettype wire

// ==== src/exu_ecl_pkg.sv ====
`default_nettype none

package exu_ecl_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////

   // general register width, default for DATA_W
   parameter int GRLEN = 32;

   // one general register value
   typedef logic [GRLEN-1:0] data_t;

   // register index, r0 is the hard zero
   typedef logic [4:0] reg_idx_t;

   // exception code as reported to csr
   typedef logic [5:0] exccode_t;

   //////////////////////////////////////////////////
   // codes
   //////////////////////////////////////////////////

   // interrupts report code 0
   parameter exccode_t EXCCODE_INTR = 6'd0;

endpackage

`default_nettype wire

// ==== src/exu_operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_operand_bypass #(
   parameter int DATA_W = 32
) (
   input  exu_ecl_pkg::reg_idx_t rs1_e,
   input  exu_ecl_pkg::reg_idx_t rs2_e,
   input  logic [DATA_W-1:0]     rf_a_e,
   input  logic [DATA_W-1:0]     rf_b_e,
   input  logic                  b_imm_e,

   input  exu_ecl_pkg::reg_idx_t rd_m,
   input  exu_ecl_pkg::reg_idx_t rd_w,
   input  logic                  wen_m,
   input  logic                  wen_w,
   input  logic [DATA_W-1:0]     rd_data_m,
   input  logic [DATA_W-1:0]     rd_data_w,

   output logic [DATA_W-1:0]     opnd_a_e,
   output logic [DATA_W-1:0]     opnd_b_e
);

   logic rs1_hit_m;
   logic rs1_hit_w;
   logic rs2_hit_m;
   logic rs2_hit_w;
   logic rs2_fwd_en;

   // r0 is never forwarded
   assign rs1_hit_m = wen_m & (rd_m == rs1_e) & (rs1_e != '0);
   assign rs1_hit_w = wen_w & (rd_w == rs1_e) & (rs1_e != '0);

   // immediate rides on rf_b_e, keep it untouched
   assign rs2_fwd_en = ~b_imm_e & (rs2_e != '0);
   assign rs2_hit_m  = rs2_fwd_en & wen_m & (rd_m == rs2_e);
   assign rs2_hit_w  = rs2_fwd_en & wen_w & (rd_w == rs2_e);

   // youngest producer first
   always_comb begin
      if (rs1_hit_m) begin
         opnd_a_e = rd_data_m;
      end else if (rs1_hit_w) begin
         opnd_a_e = rd_data_w;
      end else begin
         opnd_a_e = rf_a_e;
      end
   end

   always_comb begin
      if (rs2_hit_m) begin
         opnd_b_e = rd_data_m;
      end else if (rs2_hit_w) begin
         opnd_b_e = rd_data_w;
      end else begin
         opnd_b_e = rf_b_e;
      end
   end

endmodule

`default_nettype wire

// ==== src/exu_trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_trap_ctrl (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  valid_e,
   input  logic                  exception_e,
   input  logic                  lsu_ale_e,
   input  exu_ecl_pkg::exccode_t exccode_e,
   input  logic                  crmd_ie,
   input  logic                  timer_intr,
   input  logic                  ext_intr,

   output logic                  except,
   output exu_ecl_pkg::exccode_t exccode,
   output logic                  kill_e
);

   logic valid_prev;
   logic intr_pend;
   logic intr_take;

   // previous valid for edge detect
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_prev <= 1'b0;
      end else begin
         valid_prev <= valid_e;
      end
   end

   // ext_intr acts as hardware interrupt 0
   assign intr_pend = (timer_intr | ext_intr) & crmd_ie;

   // only on the first cycle of a new instruction in E
   assign intr_take = intr_pend & valid_e & ~valid_prev;

   // interrupt wins, the faulting instruction runs again later
   assign except  = intr_take | exception_e | lsu_ale_e;
   assign exccode = intr_take ? exu_ecl_pkg::EXCCODE_INTR : exccode_e;

   // ale depends on the killed lsu valid, so kill only on the interrupt
   assign kill_e = intr_take;

endmodule

`default_nettype wire

// ==== src/exu_wb_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_wb_select #(
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  reset,

   input  logic                  alu_wen_m,
   input  logic                  mul_valid_m,
   input  logic                  mul_wen_m,
   input  exu_ecl_pkg::reg_idx_t rf_target_m,
   input  logic [DATA_W-1:0]     alu_res_m,
   input  exu_ecl_pkg::reg_idx_t lsu_rd_m,
   input  logic                  lsu_wen_m,
   input  logic                  lsu_data_valid,
   input  logic [DATA_W-1:0]     lsu_rdata_m,
   input  logic [DATA_W-1:0]     mul_res_m,

   output exu_ecl_pkg::reg_idx_t rd_m,
   output logic                  wen_m,
   output logic [DATA_W-1:0]     rd_data_m,
   output exu_ecl_pkg::reg_idx_t irf_rd_w,
   output logic                  irf_wen_w,
   output logic [DATA_W-1:0]     irf_rd_data_w
);

   //////////////////////////////////////////////////
   // M stage select
   //////////////////////////////////////////////////

   // mul shares the alu target, loads keep their own
   assign rd_m = lsu_data_valid ? lsu_rd_m : rf_target_m;

   // any unit claiming the port
   assign wen_m = alu_wen_m | (mul_valid_m & mul_wen_m) | (lsu_wen_m & lsu_data_valid);

   always_comb begin
      if (lsu_data_valid) begin
         rd_data_m = lsu_rdata_m;
      end else if (mul_valid_m) begin
         rd_data_m = mul_res_m;
      end else begin
         rd_data_m = alu_res_m;
      end
   end

   //////////////////////////////////////////////////
   // M to W
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         irf_wen_w <= 1'b0;
      end else begin
         irf_wen_w <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      irf_rd_w      <= rd_m;
      irf_rd_data_w <= rd_data_m;
   end

endmodule

`default_nettype wire

// ==== verif/exu_ecl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_ecl_props (
   input wire logic                  clk,
   input wire logic                  reset,
   input wire logic                  lsu_valid,
   input wire logic                  lsu_ale_e,
   input wire logic                  stall_req,
   input wire logic                  valid_e,
   input wire logic                  exception_e,
   input wire exu_ecl_pkg::exccode_t exccode_e,
   input wire logic                  crmd_ie,
   input wire logic                  timer_intr,
   input wire logic                  ext_intr,
   input wire logic                  except,
   input wire exu_ecl_pkg::exccode_t exccode,
   input wire logic                  irf_wen_w
);

   logic intr_req;

   // enabled request from either interrupt source
   assign intr_req = crmd_ie & (timer_intr | ext_intr);

   // an issue without alignment fault is still pending one cycle later
   a_stall_on_issue: assert property (@(posedge clk) disable iff (reset)
      lsu_valid && !lsu_ale_e |=> stall_req)
      else $error("stall_req low in the cycle after a load or store issue");

   // without a fresh interrupt edge the exception code passes through
   a_except_follows: assert property (@(posedge clk) disable iff (reset)
      exception_e && !(intr_req && valid_e && !$past(valid_e)) |->
         except && exccode == exccode_e)
      else $error("except or exccode does not follow exception_e");

   // W write port idle right after reset
   a_wen_after_reset: assert property (@(posedge clk)
      reset |=> !irf_wen_w)
      else $error("irf_wen_w high in the cycle after reset");

endmodule

bind exu_ecl exu_ecl_props i_exu_ecl_props (
   .clk         (clk),
   .reset       (reset),
   .lsu_valid   (lsu_valid),
   .lsu_ale_e   (lsu_ale_e),
   .stall_req   (stall_req),
   .valid_e     (valid_e),
   .exception_e (exception_e),
   .exccode_e   (exccode_e),
   .crmd_ie     (crmd_ie),
   .timer_intr  (timer_intr),
   .ext_intr    (ext_intr),
   .except      (except),
   .exccode     (exccode),
   .irf_wen_w   (irf_wen_w)
);

`default_nettype wire

// ==== verif/exu_ecl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_ecl_tb;

   localparam int DATA_W    = exu_ecl_pkg::GRLEN;
   localparam int MAX_STEPS = 40;

   // one table entry, inputs of one cycle plus expected control values
   typedef struct packed {
      logic                  alu;
      logic                  mul;
      logic                  lsu;
      logic                  lwen;
      logic                  dvalid;
      logic                  wfin;
      logic                  ale;
      logic                  imm;
      logic                  valid;
      logic                  exc;
      logic                  ie;
      logic                  intr;
      logic                  exp_stall;
      logic                  exp_except;
      logic                  kill;
      exu_ecl_pkg::reg_idx_t tgt;
      exu_ecl_pkg::reg_idx_t rs1;
      exu_ecl_pkg::reg_idx_t rs2;
      exu_ecl_pkg::exccode_t code;
      exu_ecl_pkg::exccode_t exp_code;
   } step_t;

   logic clk;
   logic reset;
   exu_ecl_pkg::reg_idx_t rs1_e;
   exu_ecl_pkg::reg_idx_t rs2_e;
   exu_ecl_pkg::data_t    rf_a_e;
   exu_ecl_pkg::data_t    rf_b_e;
   logic                  b_imm_e;
   exu_ecl_pkg::reg_idx_t rf_target_e;
   logic                  alu_wen_e;
   exu_ecl_pkg::data_t    alu_res_e;
   logic                  mul_valid_e;
   logic                  mul_wen_e;
   exu_ecl_pkg::data_t    mul_res_m;
   logic                  lsu_valid_e;
   logic                  lsu_wen_e;
   exu_ecl_pkg::reg_idx_t lsu_rd_e;
   exu_ecl_pkg::data_t    lsu_rdata_m;
   logic                  lsu_data_valid;
   logic                  lsu_wr_fin;
   logic                  lsu_ale_e;
   logic                  valid_e;
   logic                  exception_e;
   exu_ecl_pkg::exccode_t exccode_e;
   logic                  crmd_ie;
   logic                  timer_intr;
   logic                  ext_intr;
   exu_ecl_pkg::data_t    opnd_a_e;
   exu_ecl_pkg::data_t    opnd_b_e;
   logic                  lsu_valid;
   logic                  mul_valid;
   logic                  except;
   exu_ecl_pkg::exccode_t exccode;
   logic                  stall_req;
   exu_ecl_pkg::reg_idx_t irf_rd_w;
   logic                  irf_wen_w;
   exu_ecl_pkg::data_t    irf_rd_data_w;

   step_t              tbl [MAX_STEPS];
   int                 n_steps;
   integer             seed;
   exu_ecl_pkg::data_t alu_res [MAX_STEPS];
   exu_ecl_pkg::data_t mul_res [MAX_STEPS];
   exu_ecl_pkg::data_t ld_data [MAX_STEPS];
   exu_ecl_pkg::data_t rf_a [MAX_STEPS];
   exu_ecl_pkg::data_t rf_b [MAX_STEPS];

   // register writes expected at W, indexed by cycle
   logic                  s_wen [MAX_STEPS + 2];
   exu_ecl_pkg::reg_idx_t s_rd [MAX_STEPS + 2];
   exu_ecl_pkg::data_t    s_data [MAX_STEPS + 2];

   exu_ecl #(.DATA_W(DATA_W)) i_exu_ecl (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopping after first error");
   endtask

   task automatic check_data(input string name, input exu_ecl_pkg::data_t exp,
                             input exu_ecl_pkg::data_t act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_idx(input string name, input exu_ecl_pkg::reg_idx_t exp,
                            input exu_ecl_pkg::reg_idx_t act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_code(input string name, input exu_ecl_pkg::exccode_t exp,
                             input exu_ecl_pkg::exccode_t act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_now($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
                            $time, name, exp, act));
      end
   endtask

   //////////////////////////////////////////////////
   // table and reference model
   //////////////////////////////////////////////////

   task automatic add_step(input logic alu, input logic mul, input logic lsu, input logic lwen,
                           input exu_ecl_pkg::reg_idx_t tgt, input exu_ecl_pkg::reg_idx_t rs1,
                           input exu_ecl_pkg::reg_idx_t rs2, input logic exp_stall);
      step_t s;
      s = '0;
      s.alu       = alu;
      s.mul       = mul;
      s.lsu       = lsu;
      s.lwen      = lwen;
      s.tgt       = tgt;
      s.rs1       = rs1;
      s.rs2       = rs2;
      s.exp_stall = exp_stall;
      tbl[n_steps] = s;
      n_steps++;
   endtask

   // trap inputs and expectations of the last entry
   task automatic set_trap(input logic valid, input logic exc, input exu_ecl_pkg::exccode_t code,
                           input logic ie, input logic intr, input logic exp_except,
                           input exu_ecl_pkg::exccode_t exp_code, input logic kill);
      tbl[n_steps-1].valid      = valid;
      tbl[n_steps-1].exc        = exc;
      tbl[n_steps-1].code       = code;
      tbl[n_steps-1].ie         = ie;
      tbl[n_steps-1].intr       = intr;
      tbl[n_steps-1].exp_except = exp_except;
      tbl[n_steps-1].exp_code   = exp_code;
      tbl[n_steps-1].kill       = kill;
   endtask

   task automatic build_table();
      n_steps = 0;
      for (int i = 0; i < MAX_STEPS; i++) begin
         alu_res[i] = $random(seed);
         mul_res[i] = $random(seed);
         ld_data[i] = $random(seed);
         rf_a[i]    = $random(seed);
         rf_b[i]    = $random(seed);
      end
      // alu chain, M / W / both / r0 / immediate forwarding
      // first write goes to r0
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd5, 5'd0, 5'd0, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd6, 5'd5, 5'd5, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd5, 5'd5, 5'd6, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd5, 5'd6, 5'd0, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd9, 5'd5, 5'd5, 1'b0);
      tbl[n_steps-1].imm = 1'b1;
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd9, 5'd0, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd9, 5'd0, 1'b0);
      // multiply, result arrives one cycle later
      add_step(1'b0, 1'b1, 1'b0, 1'b0, 5'd10, 5'd0, 5'd0, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd10, 5'd0, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd10, 5'd0, 1'b0);
      // load with three wait cycles
      add_step(1'b0, 1'b0, 1'b1, 1'b1, 5'd12, 5'd0, 5'd0, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd12, 5'd0, 1'b1);
      tbl[n_steps-1].dvalid = 1'b1;
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd12, 5'd0, 1'b0);
      // store, ends on write finish, no register write
      add_step(1'b0, 1'b0, 1'b1, 1'b0, 5'd3, 5'd0, 5'd0, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b1);
      tbl[n_steps-1].wfin = 1'b1;
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd3, 5'd0, 1'b0);
      // misaligned load, ends in its own issue cycle
      add_step(1'b0, 1'b0, 1'b1, 1'b1, 5'd7, 5'd0, 5'd0, 1'b1);
      tbl[n_steps-1].ale = 1'b1;
      set_trap(1'b0, 1'b0, 6'h09, 1'b0, 1'b0, 1'b1, 6'h09, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
      // back to back load data
      add_step(1'b0, 1'b0, 1'b1, 1'b1, 5'd13, 5'd0, 5'd0, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b1);
      tbl[n_steps-1].dvalid = 1'b1;
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd13, 5'd0, 1'b0);
      // traps
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd14, 5'd0, 5'd0, 1'b0);
      set_trap(1'b1, 1'b1, 6'h0a, 1'b0, 1'b0, 1'b1, 6'h0a, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
      add_step(1'b1, 1'b0, 1'b1, 1'b1, 5'd15, 5'd0, 5'd0, 1'b0);
      set_trap(1'b1, 1'b0, 6'h00, 1'b1, 1'b1, 1'b1, exu_ecl_pkg::EXCCODE_INTR, 1'b1);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
      set_trap(1'b1, 1'b0, 6'h00, 1'b1, 1'b1, 1'b0, 6'h00, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
      set_trap(1'b0, 1'b0, 6'h00, 1'b0, 1'b1, 1'b0, 6'h00, 1'b0);
      add_step(1'b1, 1'b0, 1'b0, 1'b0, 5'd17, 5'd0, 5'd0, 1'b0);
      set_trap(1'b1, 1'b0, 6'h00, 1'b0, 1'b1, 1'b0, 6'h00, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd17, 5'd0, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd15, 5'd0, 1'b0);
      add_step(1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 1'b0);
   endtask

   // alu / mul write two cycles after E, a load one cycle after its data
   task automatic build_schedule();
      exu_ecl_pkg::reg_idx_t held_rd;
      logic                  held_wen;
      held_rd  = '0;
      held_wen = 1'b0;
      for (int i = 0; i < MAX_STEPS + 2; i++) begin
         s_wen[i]  = 1'b0;
         s_rd[i]   = '0;
         s_data[i] = '0;
      end
      for (int t = 0; t < n_steps; t++) begin
         if (tbl[t].alu && !tbl[t].kill) begin
            s_wen[t+2]  = 1'b1;
            s_rd[t+2]   = tbl[t].tgt;
            s_data[t+2] = alu_res[t];
         end
         if (tbl[t].mul && !tbl[t].kill) begin
            s_wen[t+2]  = 1'b1;
            s_rd[t+2]   = tbl[t].tgt;
            s_data[t+2] = mul_res[t+1];
         end
         if (tbl[t].lsu && !tbl[t].kill) begin
            held_rd  = tbl[t].tgt;
            held_wen = tbl[t].lwen;
         end
         if (tbl[t].dvalid && held_wen) begin
            s_wen[t+1]  = 1'b1;
            s_rd[t+1]   = held_rd;
            s_data[t+1] = ld_data[t];
         end
      end
   endtask

   // M stage of cycle c is the write due at W in c+1
   function automatic exu_ecl_pkg::data_t fwd_value(input exu_ecl_pkg::reg_idx_t idx,
                                                    input int c,
                                                    input exu_ecl_pkg::data_t rf);
      if (idx != 5'd0 && s_wen[c+1] && s_rd[c+1] == idx) begin
         return s_data[c+1];
      end else if (idx != 5'd0 && s_wen[c] && s_rd[c] == idx) begin
         return s_data[c];
      end else begin
         return rf;
      end
   endfunction

   //////////////////////////////////////////////////
   // drive and check
   //////////////////////////////////////////////////

   task automatic drive_idle();
      rs1_e          = '0;
      rs2_e          = '0;
      rf_a_e         = '0;
      rf_b_e         = '0;
      b_imm_e        = 1'b0;
      rf_target_e    = '0;
      alu_wen_e      = 1'b0;
      alu_res_e      = '0;
      mul_valid_e    = 1'b0;
      mul_wen_e      = 1'b0;
      mul_res_m      = '0;
      lsu_valid_e    = 1'b0;
      lsu_wen_e      = 1'b0;
      lsu_rd_e       = '0;
      lsu_rdata_m    = '0;
      lsu_data_valid = 1'b0;
      lsu_wr_fin     = 1'b0;
      lsu_ale_e      = 1'b0;
      valid_e        = 1'b0;
      exception_e    = 1'b0;
      exccode_e      = '0;
      crmd_ie        = 1'b0;
      timer_intr     = 1'b0;
      ext_intr       = 1'b0;
   endtask

   task automatic drive_step(input int c);
      rs1_e          = tbl[c].rs1;
      rs2_e          = tbl[c].rs2;
      rf_a_e         = rf_a[c];
      rf_b_e         = rf_b[c];
      b_imm_e        = tbl[c].imm;
      rf_target_e    = tbl[c].tgt;
      alu_wen_e      = tbl[c].alu;
      alu_res_e      = alu_res[c];
      mul_valid_e    = tbl[c].mul;
      mul_wen_e      = tbl[c].mul;
      mul_res_m      = mul_res[c];
      lsu_valid_e    = tbl[c].lsu;
      lsu_wen_e      = tbl[c].lwen;
      lsu_rd_e       = tbl[c].tgt;
      lsu_rdata_m    = ld_data[c];
      lsu_data_valid = tbl[c].dvalid;
      lsu_wr_fin     = tbl[c].wfin;
      lsu_ale_e      = tbl[c].ale;
      valid_e        = tbl[c].valid;
      exception_e    = tbl[c].exc;
      exccode_e      = tbl[c].code;
      crmd_ie        = tbl[c].ie;
      timer_intr     = tbl[c].intr;
   endtask

   task automatic check_step(input int c);
      check_data("opnd_a_e", fwd_value(tbl[c].rs1, c, rf_a[c]), opnd_a_e);
      if (tbl[c].imm) begin
         check_data("opnd_b_e", rf_b[c], opnd_b_e);
      end else begin
         check_data("opnd_b_e", fwd_value(tbl[c].rs2, c, rf_b[c]), opnd_b_e);
      end
      check_bit("lsu_valid", tbl[c].lsu & ~tbl[c].kill, lsu_valid);
      check_bit("mul_valid", tbl[c].mul & ~tbl[c].kill, mul_valid);
      check_bit("stall_req", tbl[c].exp_stall, stall_req);
      check_bit("except", tbl[c].exp_except, except);
      if (tbl[c].exp_except) begin
         check_code("exccode", tbl[c].exp_code, exccode);
      end
      check_bit("irf_wen_w", s_wen[c], irf_wen_w);
      if (s_wen[c]) begin
         check_idx("irf_rd_w", s_rd[c], irf_rd_w);
         check_data("irf_rd_data_w", s_data[c], irf_rd_data_w);
      end
   endtask

   // load with random latency, then wait for its write
   task automatic random_load();
      int                 lat;
      int                 n;
      exu_ecl_pkg::data_t value;
      lat   = ($random(seed) & 3) + 1;
      value = $random(seed);
      n     = 0;
      drive_idle();
      lsu_valid_e = 1'b1;
      lsu_wen_e   = 1'b1;
      lsu_rd_e    = 5'd20;
      for (int i = 0; i < lat; i++) begin
         #10;
         check_bit("stall_req", 1'b1, stall_req);
         @(posedge clk);
         #2;
         lsu_valid_e = 1'b0;
      end
      lsu_data_valid = 1'b1;
      lsu_rdata_m    = value;
      #10;
      check_bit("stall_req", 1'b1, stall_req);
      @(posedge clk);
      #2;
      lsu_data_valid = 1'b0;
      while (irf_wen_w !== 1'b1) begin
         if (n >= 4) begin
            fail_now("timeout: no register write after load data");
         end else begin
            @(posedge clk);
            #2;
            n++;
         end
      end
      check_idx("irf_rd_w", 5'd20, irf_rd_w);
      check_data("irf_rd_data_w", value, irf_rd_data_w);
      check_bit("stall_req", 1'b0, stall_req);
   endtask

   initial begin
      seed  = 32'hd0bae152;
      reset = 1'b1;
      drive_idle();
      build_table();
      build_schedule();
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      for (int c = 0; c < n_steps; c++) begin
         drive_step(c);
         #10;
         check_step(c);
         @(posedge clk);
         #2;
      end
      random_load();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
